//--- logic/isaPkg.sv
// isaPkg: word and register sizes, opcodes, field positions, instruction formats, stall word
package isaPkg;

	// datapath and address width
	localparam int wordWidth = 16;
	// register selects and register count
	localparam int regSelWidth = 3;
	localparam int numRegs = 8;
	// JAL and JALR save the return address here
	localparam logic [regSelWidth-1:0] linkReg = 3'd7;

	// field positions inside the 16-bit instruction word
	localparam int opLsb = 11;
	localparam int opWidth = 5;
	localparam int rsLsb = 8;
	// Rt of R format and Rd of I1 format share bits 7..5
	localparam int rtLsb = 5;
	localparam int rdI1Lsb = 5;
	localparam int rdRLsb = 2;
	// ALU function bits of R format
	localparam int funcLsb = 0;
	localparam int funcWidth = 2;
	// immediate widths, all starting at bit 0
	localparam int imm5Width = 5;
	localparam int imm8Width = 8;
	localparam int disp11Width = 11;

	// opcodes
	localparam logic [opWidth-1:0] opHalt = 5'b00000;
	localparam logic [opWidth-1:0] opNop = 5'b00001;
	localparam logic [opWidth-1:0] opJ = 5'b00100;
	localparam logic [opWidth-1:0] opJr = 5'b00101;
	localparam logic [opWidth-1:0] opJal = 5'b00110;
	localparam logic [opWidth-1:0] opJalr = 5'b00111;
	localparam logic [opWidth-1:0] opAddi = 5'b01000;
	localparam logic [opWidth-1:0] opSubi = 5'b01001;
	localparam logic [opWidth-1:0] opXori = 5'b01010;
	localparam logic [opWidth-1:0] opAndni = 5'b01011;
	localparam logic [opWidth-1:0] opBeqz = 5'b01100;
	localparam logic [opWidth-1:0] opBnez = 5'b01101;
	localparam logic [opWidth-1:0] opBltz = 5'b01110;
	localparam logic [opWidth-1:0] opBgez = 5'b01111;
	localparam logic [opWidth-1:0] opSt = 5'b10000;
	localparam logic [opWidth-1:0] opLd = 5'b10001;
	localparam logic [opWidth-1:0] opSlbi = 5'b10010;
	localparam logic [opWidth-1:0] opStu = 5'b10011;
	localparam logic [opWidth-1:0] opLbi = 5'b11000;
	localparam logic [opWidth-1:0] opShiftR = 5'b11010;
	localparam logic [opWidth-1:0] opAluR = 5'b11011;
	localparam logic [opWidth-1:0] opSeq = 5'b11100;
	localparam logic [opWidth-1:0] opSlt = 5'b11101;
	localparam logic [opWidth-1:0] opSle = 5'b11110;

	// the four instruction layouts
	typedef enum logic [1:0] {
		fmtI1,
		fmtI2,
		fmtR,
		fmtJ
	} instrFormat;

	// NOP word fed to the control unit during a stall
	localparam logic [wordWidth-1:0] stallInstr = 16'h0800;

endpackage

//--- logic/ctrlPkg.sv
// ctrlPkg: ALU operation encoding and write-back register source encoding
package ctrlPkg;

	// operation requested from the execute stage
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluXor = 4'd2,
		aluAndn = 4'd3,
		// shift and rotate group
		aluRol = 4'd4,
		aluSll = 4'd5,
		aluRor = 4'd6,
		aluSrl = 4'd7,
		// compare group, result is 0 or 1
		aluSeq = 4'd8,
		aluSlt = 4'd9,
		aluSle = 4'd10,
		// load immediate forms
		aluLbi = 4'd11,
		aluSlbi = 4'd12,
		// operand A goes straight through
		aluPass = 4'd13
	} aluOpType;

	// where the destination register number comes from
	typedef enum logic [1:0] {
		// Rd field of the format
		wbRd = 2'd0,
		// Rs field, used by STU, LBI and SLBI
		wbRs = 2'd1,
		// fixed link register for JAL and JALR
		wbLink = 2'd2
	} wbSelType;

endpackage

//--- logic/decodeControl.sv
// decodeControl: opcode to pipeline control levels, NOP for unknown opcodes
module decodeControl import isaPkg::*, ctrlPkg::*; (
	input logic [wordWidth-1:0] instr,
	output logic isHalt,
	output logic isNop,
	output logic isJal,
	output logic isJr,
	output logic isJump,
	output logic isBranch,
	output logic isMemToReg,
	output logic isMemRead,
	output logic isMemWrite,
	output logic aluSrc,
	output logic isRegWrite,
	output aluOpType aluOp,
	output wbSelType wbRegSel
);

	logic [opWidth-1:0] opcode;
	logic [funcWidth-1:0] func;

	assign opcode = instr[opLsb +: opWidth];
	assign func = instr[funcLsb +: funcWidth];

	always_comb begin
		// everything inactive unless the opcode says otherwise
		isHalt = 1'b0;
		isNop = 1'b0;
		isJal = 1'b0;
		isJr = 1'b0;
		isJump = 1'b0;
		isBranch = 1'b0;
		isMemToReg = 1'b0;
		isMemRead = 1'b0;
		isMemWrite = 1'b0;
		aluSrc = 1'b0;
		isRegWrite = 1'b0;
		aluOp = aluPass;
		wbRegSel = wbRd;
		case (opcode)
			opHalt: isHalt = 1'b1;
			opNop: isNop = 1'b1;
			opJ: isJump = 1'b1;
			// register-indirect jump, target from rs plus imm8
			opJr: begin
				isJump = 1'b1;
				isJr = 1'b1;
			end
			// link forms write PC+2 into r7
			opJal: begin
				isJump = 1'b1;
				isJal = 1'b1;
				isRegWrite = 1'b1;
				wbRegSel = wbLink;
			end
			opJalr: begin
				isJump = 1'b1;
				isJr = 1'b1;
				isJal = 1'b1;
				isRegWrite = 1'b1;
				wbRegSel = wbLink;
			end
			// immediate arithmetic
			opAddi, opSubi, opXori, opAndni: begin
				aluSrc = 1'b1;
				isRegWrite = 1'b1;
				case (opcode)
					opAddi: aluOp = aluAdd;
					opSubi: aluOp = aluSub;
					opXori: aluOp = aluXor;
					default: aluOp = aluAndn;
				endcase
			end
			// condition itself is tested here in decode
			opBeqz, opBnez, opBltz, opBgez: isBranch = 1'b1;
			// address = rs + imm5
			opSt: begin
				aluOp = aluAdd;
				aluSrc = 1'b1;
				isMemWrite = 1'b1;
			end
			opLd: begin
				aluOp = aluAdd;
				aluSrc = 1'b1;
				isMemRead = 1'b1;
				isMemToReg = 1'b1;
				isRegWrite = 1'b1;
			end
			// store with update also writes the address back into rs
			opStu: begin
				aluOp = aluAdd;
				aluSrc = 1'b1;
				isMemWrite = 1'b1;
				isRegWrite = 1'b1;
				wbRegSel = wbRs;
			end
			opSlbi: begin
				aluOp = aluSlbi;
				aluSrc = 1'b1;
				isRegWrite = 1'b1;
				wbRegSel = wbRs;
			end
			opLbi: begin
				aluOp = aluLbi;
				aluSrc = 1'b1;
				isRegWrite = 1'b1;
				wbRegSel = wbRs;
			end
			// function bits pick the shift or rotate
			opShiftR: begin
				isRegWrite = 1'b1;
				case (func)
					2'b00: aluOp = aluRol;
					2'b01: aluOp = aluSll;
					2'b10: aluOp = aluRor;
					default: aluOp = aluSrl;
				endcase
			end
			opAluR: begin
				isRegWrite = 1'b1;
				case (func)
					2'b00: aluOp = aluAdd;
					2'b01: aluOp = aluSub;
					2'b10: aluOp = aluXor;
					default: aluOp = aluAndn;
				endcase
			end
			opSeq: begin
				aluOp = aluSeq;
				isRegWrite = 1'b1;
			end
			opSlt: begin
				aluOp = aluSlt;
				isRegWrite = 1'b1;
			end
			opSle: begin
				aluOp = aluSle;
				isRegWrite = 1'b1;
			end
			// unsupported or unknown opcode behaves as NOP
			default: isNop = 1'b1;
		endcase
	end

endmodule

//--- logic/fieldDecode.sv
// fieldDecode: format classification, register select fields, immediate extension
module fieldDecode import isaPkg::*; (
	input logic [wordWidth-1:0] instr,
	output logic [regSelWidth-1:0] readReg1,
	output logic [regSelWidth-1:0] readReg2,
	output logic [regSelWidth-1:0] writeRegSel,
	output logic [wordWidth-1:0] immed
);

	logic [opWidth-1:0] opcode;
	instrFormat format;
	logic [regSelWidth-1:0] rs;

	assign opcode = instr[opLsb +: opWidth];
	assign rs = instr[rsLsb +: regSelWidth];

	// format from opcode, I1 covers everything not listed
	always_comb begin
		case (opcode)
			opJ, opJal: format = fmtJ;
			opJr, opJalr, opBeqz, opBnez, opBltz, opBgez, opLbi, opSlbi: format = fmtI2;
			opShiftR, opAluR, opSeq, opSlt, opSle: format = fmtR;
			default: format = fmtI1;
		endcase
	end

	// rs always sits in bits 10..8
	assign readReg1 = rs;
	// Rt of R format, or Rd of I1 format which is the store data register
	assign readReg2 = instr[rtLsb +: regSelWidth];

	always_comb begin
		case (format)
			fmtR: writeRegSel = instr[rdRLsb +: regSelWidth];
			fmtI1: writeRegSel = instr[rdI1Lsb +: regSelWidth];
			default: writeRegSel = rs;
		endcase
		// exceptions to the format rule
		case (opcode)
			opStu, opLbi, opSlbi: writeRegSel = rs;
			opJal, opJalr: writeRegSel = linkReg;
			default: ;
		endcase
	end

	always_comb begin
		case (format)
			// logical immediates are unsigned
			fmtI1: begin
				if (opcode == opXori || opcode == opAndni)
					immed = {{(wordWidth-imm5Width){1'b0}}, instr[imm5Width-1:0]};
				else
					immed = {{(wordWidth-imm5Width){instr[imm5Width-1]}}, instr[imm5Width-1:0]};
			end
			// slbi shifts in an unsigned byte
			fmtI2: begin
				if (opcode == opSlbi)
					immed = {{(wordWidth-imm8Width){1'b0}}, instr[imm8Width-1:0]};
				else
					immed = {{(wordWidth-imm8Width){instr[imm8Width-1]}}, instr[imm8Width-1:0]};
			end
			fmtJ: immed = {{(wordWidth-disp11Width){instr[disp11Width-1]}},
				instr[disp11Width-1:0]};
			// R format has no immediate
			default: immed = '0;
		endcase
	end

endmodule

//--- logic/registerFile.sv
// registerFile: 8x16 registers, two combinational read ports, optional write bypass
module registerFile import isaPkg::*; #(
	parameter bit bypassEnable = 1'b1
) (
	input logic clk,
	input logic rstN,
	input logic [regSelWidth-1:0] readReg1,
	input logic [regSelWidth-1:0] readReg2,
	input logic [regSelWidth-1:0] writeReg,
	input logic [wordWidth-1:0] writeData,
	input logic writeEn,
	output logic [wordWidth-1:0] rdData1,
	output logic [wordWidth-1:0] rdData2
);

	logic [wordWidth-1:0] regs [numRegs];

	// one write port, written on the rising edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeReg] <= writeData;
		end
	end

	// read with optional forward of the word being written this cycle
	function automatic logic [wordWidth-1:0] readPort(input logic [regSelWidth-1:0] sel);
		logic hit;
		hit = bypassEnable && writeEn && (sel == writeReg);
		return hit ? writeData : regs[sel];
	endfunction

	always_comb begin
		rdData1 = readPort(readReg1);
		rdData2 = readPort(readReg2);
	end

endmodule

//--- logic/branchResolve.sv
// branchResolve: branch condition, target adder, next PC select, flush decision
module branchResolve import isaPkg::*; (
	input logic [wordWidth-1:0] instr,
	input logic [wordWidth-1:0] rsVal,
	input logic [wordWidth-1:0] immed,
	input logic [wordWidth-1:0] incrPc,
	input logic isBranch,
	input logic isJump,
	input logic isJr,
	output logic [wordWidth-1:0] pcNext,
	output logic flush
);

	logic [opWidth-1:0] opcode;
	logic taken;
	logic redirect;
	logic [wordWidth-1:0] targetBase;
	logic [wordWidth-1:0] target;

	assign opcode = instr[opLsb +: opWidth];

	// condition on rs, sign taken from the top bit
	always_comb begin
		case (opcode)
			opBeqz: taken = (rsVal == '0);
			opBnez: taken = (rsVal != '0);
			opBltz: taken = rsVal[wordWidth-1];
			opBgez: taken = !rsVal[wordWidth-1];
			default: taken = 1'b0;
		endcase
	end

	// JR and JALR are relative to rs, all others to PC+2
	assign targetBase = isJr ? rsVal : incrPc;
	// for J and JAL immed already holds the extended disp11
	assign target = targetBase + immed;

	// jumps always redirect, branches only when taken
	assign redirect = isJump || (isBranch && taken);
	assign pcNext = redirect ? target : incrPc;

	// a redirect that lands on PC+2 needs no flush
	assign flush = (isBranch || isJump) && (pcNext != incrPc);

endmodule

//--- logic/decodeStage.sv
// decodeStage: stall mux, control unit, field decode, register file, branch resolve
module decodeStage import isaPkg::*, ctrlPkg::*; #(
	parameter bit bypassEnable = 1'b1
) (
	input logic clk,
	input logic rstN,
	input logic [wordWidth-1:0] instr,
	input logic [wordWidth-1:0] currPc,
	input logic [wordWidth-1:0] incrPc,
	input logic stall,
	input logic [regSelWidth-1:0] writeReg,
	input logic [wordWidth-1:0] writeData,
	input logic writeEn,
	output logic isHalt,
	output logic isNop,
	output logic isJal,
	output logic isJr,
	output logic isJump,
	output logic isBranch,
	output logic isMemToReg,
	output logic isMemRead,
	output logic isMemWrite,
	output logic aluSrc,
	output logic isRegWrite,
	output aluOpType aluOp,
	output logic [regSelWidth-1:0] readReg1,
	output logic [regSelWidth-1:0] readReg2,
	output logic [regSelWidth-1:0] writeRegSel,
	output logic [wordWidth-1:0] immed,
	output logic [wordWidth-1:0] rdData1,
	output logic [wordWidth-1:0] rdData2,
	output logic [wordWidth-1:0] pcNext,
	output logic flush,
	// PC of this instruction, carried on for later stages
	output logic [wordWidth-1:0] decodePc
);

	logic [wordWidth-1:0] ctrlInstr;

	// bubble only hides control, fields still come from the real word
	assign ctrlInstr = stall ? stallInstr : instr;
	assign decodePc = currPc;

	// destination select, link register included, comes from fieldDecode
	decodeControl uCtrl (
		.instr(ctrlInstr),
		.isHalt(isHalt),
		.isNop(isNop),
		.isJal(isJal),
		.isJr(isJr),
		.isJump(isJump),
		.isBranch(isBranch),
		.isMemToReg(isMemToReg),
		.isMemRead(isMemRead),
		.isMemWrite(isMemWrite),
		.aluSrc(aluSrc),
		.isRegWrite(isRegWrite),
		.aluOp(aluOp),
		.wbRegSel()
	);

	fieldDecode uFields (
		.instr(instr),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeRegSel(writeRegSel),
		.immed(immed)
	);

	registerFile #(
		.bypassEnable(bypassEnable)
	) uRegs (
		.clk(clk),
		.rstN(rstN),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeReg(writeReg),
		.writeData(writeData),
		.writeEn(writeEn),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	// rs value feeds both the condition test and the JR adder
	branchResolve uBranch (
		.instr(instr),
		.rsVal(rdData1),
		.immed(immed),
		.incrPc(incrPc),
		.isBranch(isBranch),
		.isJump(isJump),
		.isJr(isJr),
		.pcNext(pcNext),
		.flush(flush)
	);

endmodule

//--- testbench/tbClock.sv
// tbClock: free-running clock and power-on reset for the testbench
module tbClock #(
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 1ps;

	// 100 ns period
	localparam realtime halfPeriod = 50.0;

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// held low over the first rising edges, released on a falling edge
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

//--- testbench/tbChecker.sv
// tbChecker: compares DUT outputs with the expected values of each entry, keeps the counts
module tbChecker import isaPkg::*; (
	input logic clk,
	input logic checkEn,
	input int entryIdx,
	input logic [wordWidth-1:0] instr,
	// DUT outputs, control bits packed the same way as the expected word
	input logic [14:0] actCtrl,
	input logic [regSelWidth-1:0] readReg1,
	input logic [regSelWidth-1:0] readReg2,
	input logic [regSelWidth-1:0] writeRegSel,
	input logic [wordWidth-1:0] immed,
	input logic [wordWidth-1:0] rdData1,
	input logic [wordWidth-1:0] rdData2,
	input logic [wordWidth-1:0] pcNext,
	input logic flush,
	input logic [wordWidth-1:0] decodePc,
	// expected values of the entry being applied
	input logic [14:0] expCtrl,
	input logic [wordWidth-1:0] expImmed,
	input logic [regSelWidth-1:0] expRs,
	input logic [regSelWidth-1:0] expRt,
	input logic [regSelWidth-1:0] expWr,
	input logic [wordWidth-1:0] expRd1,
	input logic [wordWidth-1:0] expRd2,
	input logic [wordWidth-1:0] expPc,
	input logic expFlush,
	input logic [wordWidth-1:0] expDecodePc,
	output int passCount,
	output int failCount
);
	timeunit 1ns;
	timeprecision 1ps;

	// mismatches found in the current entry
	int errors;

	task automatic compareValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s in entry %0d: expected 0x%h, got 0x%h",
				name, entryIdx, expected, actual);
			errors++;
		end
	endtask

	// inputs change on the falling edge, the register file only after this edge
	always @(posedge clk) begin
		if (checkEn) begin
			errors = 0;
			compareValue("control word", {1'b0, expCtrl}, {1'b0, actCtrl});
			compareValue("immed", expImmed, immed);
			compareValue("readReg1", 16'(expRs), 16'(readReg1));
			compareValue("readReg2", 16'(expRt), 16'(readReg2));
			compareValue("writeRegSel", 16'(expWr), 16'(writeRegSel));
			compareValue("rdData1", expRd1, rdData1);
			compareValue("rdData2", expRd2, rdData2);
			compareValue("pcNext", expPc, pcNext);
			compareValue("flush", 16'(expFlush), 16'(flush));
			compareValue("decodePc", expDecodePc, decodePc);
			if (errors == 0) begin
				passCount++;
				$display("entry %0d instr 0x%h: ok", entryIdx, instr);
			end else begin
				failCount++;
				$display("entry %0d instr 0x%h: %0d mismatches", entryIdx, instr, errors);
			end
		end
	end

endmodule

//--- testbench/tbTop.sv
// tbTop: stimulus table, apply loop, register model, DUT instance and final verdict
module tbTop import isaPkg::*, ctrlPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// class of the data written in an entry
	localparam logic [1:0] kNone = 2'd0;
	localparam logic [1:0] kPos = 2'd1;
	localparam logic [1:0] kNeg = 2'd2;
	localparam logic [1:0] kAny = 2'd3;

	localparam int resetTimeout = 20;
	// whole run in ns, far above the table length
	localparam realtime runLimit = 100000.0;

	// {halt, nop, jal, jr, jump, branch, memToReg, memRead, memWrite, aluSrc, regWrite, aluOp}
	localparam logic [14:0] nopCtrl = {11'b01000000000, aluPass};
	localparam logic [14:0] haltCtrl = {11'b10000000000, aluPass};
	localparam logic [14:0] ldCtrl = {11'b00000011011, aluAdd};
	localparam logic [14:0] stCtrl = {11'b00000000110, aluAdd};
	localparam logic [14:0] addiCtrl = {11'b00000000011, aluAdd};
	localparam logic [14:0] xoriCtrl = {11'b00000000011, aluXor};
	localparam logic [14:0] slbiCtrl = {11'b00000000011, aluSlbi};
	localparam logic [14:0] lbiCtrl = {11'b00000000011, aluLbi};
	localparam logic [14:0] rAddCtrl = {11'b00000000001, aluAdd};
	localparam logic [14:0] rSubCtrl = {11'b00000000001, aluSub};
	localparam logic [14:0] branchCtrl = {11'b00000100000, aluPass};
	localparam logic [14:0] jCtrl = {11'b00001000000, aluPass};
	localparam logic [14:0] jalCtrl = {11'b00101000001, aluPass};
	localparam logic [14:0] jrCtrl = {11'b00011000000, aluPass};
	localparam logic [14:0] jalrCtrl = {11'b00111000001, aluPass};

	// one row of the table
	typedef struct packed {
		logic [15:0] instr;
		logic [15:0] incrPc;
		logic stall;
		logic [2:0] wrReg;
		logic [1:0] wrKind;
		logic [15:0] expImmed;
		logic [2:0] expRs;
		logic [2:0] expRt;
		logic [2:0] expWr;
		logic [14:0] expCtrl;
		// pcNext is the target, else incrPc
		logic redirect;
		// target base is Rs, else incrPc
		logic jrBase;
	} entryT;

	logic clk;
	logic rstN;
	// DUT inputs
	logic [wordWidth-1:0] instr;
	logic [wordWidth-1:0] currPc;
	logic [wordWidth-1:0] incrPc;
	logic stall;
	logic [regSelWidth-1:0] writeReg;
	logic [wordWidth-1:0] writeData;
	logic writeEn;
	// DUT outputs
	logic isHalt;
	logic isNop;
	logic isJal;
	logic isJr;
	logic isJump;
	logic isBranch;
	logic isMemToReg;
	logic isMemRead;
	logic isMemWrite;
	logic aluSrc;
	logic isRegWrite;
	aluOpType aluOp;
	logic [regSelWidth-1:0] readReg1;
	logic [regSelWidth-1:0] readReg2;
	logic [regSelWidth-1:0] writeRegSel;
	logic [wordWidth-1:0] immed;
	logic [wordWidth-1:0] rdData1;
	logic [wordWidth-1:0] rdData2;
	logic [wordWidth-1:0] pcNext;
	logic flush;
	logic [wordWidth-1:0] decodePc;
	// checker side
	logic [14:0] actCtrl;
	logic checkEn;
	int entryIdx;
	logic [14:0] expCtrl;
	logic [wordWidth-1:0] expImmed;
	logic [regSelWidth-1:0] expRs;
	logic [regSelWidth-1:0] expRt;
	logic [regSelWidth-1:0] expWr;
	logic [wordWidth-1:0] expRd1;
	logic [wordWidth-1:0] expRd2;
	logic [wordWidth-1:0] expPc;
	logic expFlush;
	logic [wordWidth-1:0] expDecodePc;
	int passCount;
	int failCount;

	entryT entries[$];
	// register contents as the DUT should hold them
	logic [wordWidth-1:0] model [numRegs];
	int seed = 32'he574c7ca;

	assign actCtrl = {isHalt, isNop, isJal, isJr, isJump, isBranch,
		isMemToReg, isMemRead, isMemWrite, aluSrc, isRegWrite, aluOp};

	tbClock clockGen (
		.clk(clk),
		.rstN(rstN)
	);

	decodeStage #(
		.bypassEnable(1'b1)
	) UUT (.*);

	tbChecker outputCheck (.*);

	// instruction builders for the four layouts
	function automatic logic [15:0] encI1(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] encI2(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] encR(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] encJ(input logic [4:0] op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic addEntry(input logic [15:0] ins, input logic stl, input logic [2:0] wr,
		input logic [1:0] kind, input logic [15:0] imm, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] wsel, input logic [14:0] ctrl,
		input logic redir, input logic jrb);
		entryT e;
		e.instr = ins;
		// each entry sits two bytes after the previous one
		e.incrPc = 16'h4000 + 16'(2 * entries.size());
		e.stall = stl;
		e.wrReg = wr;
		e.wrKind = kind;
		e.expImmed = imm;
		e.expRs = rs;
		e.expRt = rt;
		e.expWr = wsel;
		e.expCtrl = ctrl;
		e.redirect = redir;
		e.jrBase = jrb;
		entries.push_back(e);
	endtask

	task automatic buildTable();
		// all registers read zero after reset
		addEntry(encR(opAluR, 0, 1, 2, 0), 0, 0, kNone, 16'h0000, 0, 1, 2, rAddCtrl, 0, 0);
		addEntry(encR(opAluR, 2, 3, 4, 1), 0, 0, kNone, 16'h0000, 2, 3, 4, rSubCtrl, 0, 0);
		addEntry(encR(opAluR, 4, 5, 6, 0), 0, 0, kNone, 16'h0000, 4, 5, 6, rAddCtrl, 0, 0);
		addEntry(encR(opAluR, 6, 7, 1, 1), 0, 0, kNone, 16'h0000, 6, 7, 1, rSubCtrl, 0, 0);
		// fill registers, reading back the previous write and the bypassed one
		addEntry(stallInstr, 0, 1, kPos, 16'h0000, 0, 0, 0, nopCtrl, 0, 0);
		addEntry(encR(opAluR, 1, 2, 3, 0), 0, 2, kNeg, 16'h0000, 1, 2, 3, rAddCtrl, 0, 0);
		addEntry(encR(opAluR, 2, 3, 7, 1), 0, 3, kAny, 16'h0000, 2, 3, 7, rSubCtrl, 0, 0);
		addEntry(stallInstr, 0, 5, kPos, 16'h0000, 0, 0, 0, nopCtrl, 0, 0);
		addEntry(encI1(opLd, 4, 6, 5'h1F), 0, 4, kAny, 16'hFFFF, 4, 6, 6, ldCtrl, 0, 0);
		// immediate extension and control words
		addEntry(encI1(opAddi, 1, 3, 5'h13), 0, 0, kNone, 16'hFFF3, 1, 3, 3, addiCtrl, 0, 0);
		addEntry(encI1(opAddi, 2, 4, 5'h0A), 0, 0, kNone, 16'h000A, 2, 4, 4, addiCtrl, 0, 0);
		addEntry(encI1(opXori, 3, 5, 5'h15), 0, 0, kNone, 16'h0015, 3, 5, 5, xoriCtrl, 0, 0);
		addEntry(encI2(opSlbi, 6, 8'h9C), 0, 0, kNone, 16'h009C, 6, 4, 6, slbiCtrl, 0, 0);
		addEntry(encI2(opLbi, 2, 8'h85), 0, 0, kNone, 16'hFF85, 2, 4, 2, lbiCtrl, 0, 0);
		addEntry(encI2(opLbi, 7, 8'h7F), 0, 0, kNone, 16'h007F, 7, 3, 7, lbiCtrl, 0, 0);
		addEntry(encI1(opSt, 1, 2, 5'h04), 0, 0, kNone, 16'h0004, 1, 2, 2, stCtrl, 0, 0);
		addEntry(encR(opAluR, 3, 4, 5, 0), 0, 0, kNone, 16'h0000, 3, 4, 5, rAddCtrl, 0, 0);
		addEntry(encR(opAluR, 6, 1, 2, 1), 0, 0, kNone, 16'h0000, 6, 1, 2, rSubCtrl, 0, 0);
		addEntry(16'h0000, 0, 0, kNone, 16'h0000, 0, 0, 0, haltCtrl, 0, 0);
		// branches on r0 zero, r1 positive, r2 negative
		addEntry(encI2(opBeqz, 0, 8'h10), 0, 0, kNone, 16'h0010, 0, 0, 0, branchCtrl, 1, 0);
		addEntry(encI2(opBeqz, 1, 8'h10), 0, 0, kNone, 16'h0010, 1, 0, 1, branchCtrl, 0, 0);
		addEntry(encI2(opBeqz, 2, 8'h10), 0, 0, kNone, 16'h0010, 2, 0, 2, branchCtrl, 0, 0);
		addEntry(encI2(opBnez, 0, 8'hF0), 0, 0, kNone, 16'hFFF0, 0, 7, 0, branchCtrl, 0, 0);
		addEntry(encI2(opBnez, 1, 8'hF0), 0, 0, kNone, 16'hFFF0, 1, 7, 1, branchCtrl, 1, 0);
		addEntry(encI2(opBnez, 2, 8'hF0), 0, 0, kNone, 16'hFFF0, 2, 7, 2, branchCtrl, 1, 0);
		addEntry(encI2(opBltz, 0, 8'h10), 0, 0, kNone, 16'h0010, 0, 0, 0, branchCtrl, 0, 0);
		addEntry(encI2(opBltz, 1, 8'h10), 0, 0, kNone, 16'h0010, 1, 0, 1, branchCtrl, 0, 0);
		addEntry(encI2(opBltz, 2, 8'h10), 0, 0, kNone, 16'h0010, 2, 0, 2, branchCtrl, 1, 0);
		addEntry(encI2(opBgez, 0, 8'hF0), 0, 0, kNone, 16'hFFF0, 0, 7, 0, branchCtrl, 1, 0);
		addEntry(encI2(opBgez, 1, 8'hF0), 0, 0, kNone, 16'hFFF0, 1, 7, 1, branchCtrl, 1, 0);
		addEntry(encI2(opBgez, 2, 8'hF0), 0, 0, kNone, 16'hFFF0, 2, 7, 2, branchCtrl, 0, 0);
		// jumps, the last J lands on incrPc itself
		addEntry(encJ(opJ, 11'h412), 0, 0, kNone, 16'hFC12, 4, 0, 4, jCtrl, 1, 0);
		addEntry(encJ(opJ, 11'h0A0), 0, 0, kNone, 16'h00A0, 0, 5, 0, jCtrl, 1, 0);
		addEntry(encJ(opJal, 11'h3FE), 0, 0, kNone, 16'h03FE, 3, 7, 7, jalCtrl, 1, 0);
		addEntry(encJ(opJ, 11'h000), 0, 0, kNone, 16'h0000, 0, 0, 0, jCtrl, 1, 0);
		addEntry(encI2(opJr, 5, 8'h08), 0, 0, kNone, 16'h0008, 5, 0, 5, jrCtrl, 1, 1);
		addEntry(encI2(opJalr, 1, 8'hFC), 0, 0, kNone, 16'hFFFC, 1, 7, 7, jalrCtrl, 1, 1);
		// stalled flow changes become bubbles, fields stay
		addEntry(encI2(opBeqz, 0, 8'h10), 1, 0, kNone, 16'h0010, 0, 0, 0, nopCtrl, 0, 0);
		addEntry(encI2(opBnez, 1, 8'hF0), 1, 0, kNone, 16'hFFF0, 1, 7, 1, nopCtrl, 0, 0);
		addEntry(encJ(opJal, 11'h3FE), 1, 0, kNone, 16'h03FE, 3, 7, 7, nopCtrl, 0, 0);
	endtask

	// random write data of the requested sign class
	function automatic logic [15:0] makeData(input logic [1:0] kind);
		logic [15:0] r;
		if (kind == kNone)
			return 16'h0000;
		r = 16'($random(seed));
		case (kind)
			// bit 0 forced so the value is never zero
			kPos: return (r & 16'h7FFF) | 16'h0001;
			kNeg: return r | 16'h8000;
			default: return r;
		endcase
	endfunction

	// a register written in this cycle reads as the write data
	function automatic logic [15:0] expectRead(input logic [2:0] sel, input logic we,
		input logic [2:0] wreg, input logic [15:0] wdata);
		return (we && sel == wreg) ? wdata : model[sel];
	endfunction

	task automatic applyEntry(input int idx);
		entryT e;
		logic [15:0] data;
		logic [15:0] base;
		e = entries[idx];
		data = makeData(e.wrKind);
		instr = e.instr;
		incrPc = e.incrPc;
		currPc = e.incrPc - 16'd2;
		stall = e.stall;
		writeEn = (e.wrKind != kNone);
		writeReg = e.wrReg;
		writeData = data;
		expCtrl = e.expCtrl;
		expImmed = e.expImmed;
		expRs = e.expRs;
		expRt = e.expRt;
		expWr = e.expWr;
		expRd1 = expectRead(e.expRs, writeEn, e.wrReg, data);
		expRd2 = expectRead(e.expRt, writeEn, e.wrReg, data);
		base = e.jrBase ? expRd1 : e.incrPc;
		expPc = e.redirect ? base + e.expImmed : e.incrPc;
		// flush only for a branch or jump that leaves the sequential path
		expFlush = (e.expCtrl[10] || e.expCtrl[9]) && (expPc != e.incrPc);
		// the PC of this instruction goes on unchanged
		expDecodePc = currPc;
		if (writeEn)
			model[e.wrReg] = data;
		entryIdx = idx;
		checkEn = 1'b1;
	endtask

	task automatic waitReset(output bit released);
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < resetTimeout) begin
			@(posedge clk);
			cycles++;
		end
		released = (rstN === 1'b1);
	endtask

	initial begin : mainFlow
		bit resetOk;
		// stall high keeps the control outputs at NOP until the first entry
		instr = stallInstr;
		currPc = '0;
		incrPc = '0;
		stall = 1'b1;
		writeReg = '0;
		writeData = '0;
		writeEn = 1'b0;
		checkEn = 1'b0;
		entryIdx = 0;
		expCtrl = '0;
		expImmed = '0;
		expRs = '0;
		expRt = '0;
		expWr = '0;
		expRd1 = '0;
		expRd2 = '0;
		expPc = '0;
		expFlush = 1'b0;
		expDecodePc = '0;
		for (int i = 0; i < numRegs; i++) begin
			model[i] = '0;
		end
		buildTable();
		waitReset(resetOk);
		if (resetOk) begin
			foreach (entries[i]) begin
				@(negedge clk);
				applyEntry(i);
			end
			// the last entry is checked on the edge before this one
			@(negedge clk);
			checkEn = 1'b0;
			writeEn = 1'b0;
			stall = 1'b1;
		end else begin
			$display("Reset was not released within %0d clock cycles", resetTimeout);
		end
		$display("%0d entries checked, %0d passed, %0d failed",
			passCount + failCount, passCount, failCount);
		if (resetOk && failCount == 0 && passCount == entries.size()) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// stops a run whose clock or apply loop got stuck
	initial begin : watchdog
		#(runLimit);
		$display("Run did not finish within %0t", runLimit);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- sources.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/decodeControl.sv
logic/fieldDecode.sv
logic/registerFile.sv
logic/branchResolve.sv
logic/decodeStage.sv
testbench/tbClock.sv
testbench/tbChecker.sv
testbench/tbTop.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - logic/isaPkg.sv
  - logic/ctrlPkg.sv
  - logic/decodeControl.sv
  - logic/fieldDecode.sv
  - logic/registerFile.sv
  - logic/branchResolve.sv
  - logic/decodeStage.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/tbChecker.sv
      - testbench/tbTop.sv
